/* Bender.yml */
package:
  name: tree_noc

sources:
  - files:
      - tree_noc_pkg.sv
      - flit_fifo.sv
      - rr_arbiter.sv
      - tree_router.sv
      - tree_noc_top.sv
  - target: test
    files:
      - tree_noc_asserts.sv
      - tree_noc_tb.sv

/* compile.f */
tree_noc_pkg.sv
flit_fifo.sv
rr_arbiter.sv
tree_router.sv
tree_noc_top.sv
tree_noc_asserts.sv
tree_noc_tb.sv

/* flit_fifo.sv */
`timescale 1ns/1ps

// input buffer of a router port
// circular buffer with read/write pointers and a fill count
module flit_fifo
    import tree_noc_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    output logic  in_ready,
    input  flit_t in_flit,
    output logic  out_valid,
    input  logic  out_ready,
    output flit_t out_flit
);

    flit_t mem [DEPTH];                         // storage, no reset needed

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;          // 0 .. DEPTH entries
    logic                       push;
    logic                       pop;

    // ready only looks at our own fill level
    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != 0);
    assign out_flit  = mem[rd_ptr];             // head straight from the array

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;                       // empty after reset
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // idle or push and pop together
            endcase
        end
    end

endmodule

/* rr_arbiter.sv */
`timescale 1ns/1ps

// round-robin arbiter for one router output
// the winner keeps its grant until advance so a stalled flit stays put
module rr_arbiter #(
    parameter int N = 2
) (
    input  logic         clk,
    input  logic         reset,
    input  logic [N-1:0] request,
    output logic [N-1:0] grant,     // one-hot
    input  logic         advance    // granted flit moved this cycle
);

    logic [$clog2(N)-1:0] ptr;      // highest priority input
    logic [$clog2(N)-1:0] win;      // index of current grant
    logic [N-1:0]         rr_grant; // fresh pick from the pointer
    logic [N-1:0]         held;     // last cycle's grant
    logic                 locked;   // held grant still waiting on ready

    // first requester at or after ptr
    always_comb begin : pick
        int idx;
        rr_grant = '0;
        for (int i = N - 1; i >= 0; i--) begin
            idx = (int'(ptr) + i) % N;
            if (request[idx]) begin
                rr_grant      = '0;
                rr_grant[idx] = 1'b1;
            end
        end
    end

    // stick with the old winner while it still asks
    assign grant = (locked && |(held & request)) ? held : rr_grant;

    always_comb begin : encode
        win = '0;
        for (int i = 0; i < N; i++) begin
            if (grant[i]) win = i[$clog2(N)-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr    <= '0;
            locked <= 1'b0;
            held   <= '0;
        end else begin
            held <= grant;
            if (advance) begin
                ptr    <= (win == N - 1) ? '0 : win + 1'b1;   // step past the winner
                locked <= 1'b0;
            end else begin
                locked <= |grant;               // stalled grant, freeze it
            end
        end
    end

endmodule

/* tree_noc_asserts.sv */
`timescale 1ns/1ps

// endpoint handshake checks, bound into tree_noc_top
module tree_noc_asserts
    import tree_noc_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input logic [NE-1:0] in_ready,
    input logic [NE-1:0] out_valid,
    input logic [NE-1:0] out_ready,
    input flit_t         out_flit [NE]
);

    for (genvar e = 0; e < NE; e++) begin : g_ep

        // a stalled flit stays on the port unchanged
        hold_a : assert property (@(posedge clk) disable iff (reset)
            out_valid[e] && !out_ready[e] |=> out_valid[e] && $stable(out_flit[e]))
            else $error("endpoint %0d changed or dropped a stalled flit", e);

        // FIFOs empty straight after reset
        idle_a : assert property (@(posedge clk) reset |=> !out_valid[e])
            else $error("endpoint %0d out_valid high after reset", e);

        ready_a : assert property (@(posedge clk) reset |=> in_ready[e])   // nothing queued yet
            else $error("endpoint %0d in_ready low after reset", e);

    end

endmodule

/* tree_noc_golden.txt */
// src_dst_data_phase in hex with one single-flit packet per line
// phase 1 local, 2 cross root, 3 hot spot, 4 spread, 5 back-pressure
0_1_11_1
1_0_12_1
2_3_13_1
3_2_14_1
0_2_21_2
1_3_22_2
2_1_23_2
3_0_24_2
0_2_31_3
1_2_32_3
2_2_33_3
3_2_34_3
0_2_35_3
1_2_36_3
2_2_37_3
3_2_38_3
0_3_41_4
1_2_42_4
2_1_43_4
3_0_44_4
0_1_45_4
1_0_46_4
2_3_47_4
3_2_48_4
0_1_51_5
0_1_52_5
0_0_53_5
0_3_54_5
0_2_55_5
1_0_56_5
1_2_57_5
1_1_58_5
2_0_59_5
2_3_5a_5
3_1_5b_5
3_3_5c_5

/* tree_noc_pkg.sv */
package tree_noc_pkg;

    // tree shape
    localparam int K = 2;                       // arity
    localparam int L = 2;                       // layers, leaf is 0 and root is L-1
    localparam int NE = K ** L;                 // endpoints under the leaves
    localparam int MAX_P = K + 1;               // K down ports plus one up port
    localparam int PORTW = $clog2(MAX_P);       // router port index width

    // addressing and payload
    localparam int KW = (K > 1) ? $clog2(K) : 1;    // bits per base-K digit
    localparam int AW = L * KW;                 // digit 0 picks the leaf port
    localparam int DW = 8;
    localparam int FIFO_DEPTH = 4;              // per input port

    typedef logic [AW-1:0] addr_t;

    typedef struct packed {
        addr_t         dest;
        addr_t         src;
        logic [DW-1:0] data;
    } flit_t;

    function automatic int powi(input int base, input int e);
        int r;
        r = 1;
        for (int n = 0; n < e; n++) begin
            r = r * base;
        end
        return r;
    endfunction

    // number of routers in the layers above lyr
    // lyr of -1 gives the whole tree
    function automatic int router_index(input int lyr);
        int n;
        n = 0;
        for (int j = lyr + 1; j < L; j++) begin
            n = n + powi(K, L - 1 - j);         // layer j holds K^(L-1-j) routers
        end
        return n;
    endfunction

    // base-K digit i of an endpoint address
    function automatic logic [KW-1:0] digit(input addr_t a, input int i);
        return a[i*KW +: KW];
    endfunction

    localparam int NR = router_index(-1);       // 1 + K + ... + K^(L-1)

endpackage

/* tree_noc_tb.sv */
`timescale 1ns/1ps

// testbench for the tree NoC
// golden packets run phase by phase
// scoreboard keyed by source and destination
module tree_noc_tb
    import tree_noc_pkg::*;
();

    localparam int MAX_PKT      = 64;
    localparam int RESET_CYCLES = 5;

    logic          clk;
    logic          reset;
    logic [NE-1:0] in_valid;
    wire  [NE-1:0] in_ready;
    flit_t         in_flit [NE];
    wire  [NE-1:0] out_valid;
    logic [NE-1:0] out_ready;
    wire  flit_t   out_flit [NE];

    logic [19:0] golden [MAX_PKT];  // src, dst, data, phase as hex fields
    int num_pkt;
    int cycle_cnt;
    int errors;
    int tests_failed;
    int seed = 32'haff7d669;
    bit loaded;
    bit sent [MAX_PKT];             // accepted by the network
    bit got [MAX_PKT];              // delivered and checked
    int acc_cycle [MAX_PKT];
    int pair_cnt [NE][NE];          // arrivals per source/dest in this phase
    int offer [NE];                 // packet index on each input or -1

    tree_noc_top i_tree_noc_top (.*);

    bind tree_noc_top tree_noc_asserts i_asserts (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;   // read at negedge only

    initial begin : watchdog
        wait (loaded);
        repeat (RESET_CYCLES + 200 * num_pkt) @(posedge clk);
        $display("timeout after %0d cycles, deliveries still missing",
                 RESET_CYCLES + 200 * num_pkt);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("at %0t: %s", $time, what);
        errors++;
    endtask

    // one cycle per router on the way up and back down
    function automatic int hop_latency(input int s, input int d);
        int span;
        int up;
        span = K;
        up   = 0;
        while ((s / span) != (d / span)) begin
            span = span * K;
            up++;
        end
        return 2 * up + 1;
    endfunction

    // n-th golden packet of one source/dest pair within a phase
    function automatic int find_packet(input int ph, input int s, input int d, input int n);
        int seen;
        seen = 0;
        for (int i = 0; i < num_pkt; i++) begin
            if (golden[i][3:0] == ph && golden[i][19:16] == s && golden[i][15:12] == d) begin
                if (seen == n) return i;
                seen++;
            end
        end
        return -1;
    endfunction

    task automatic check_delivery(input int ph, input int d, input bit timed);
        flit_t f;
        int    s;
        int    idx;
        int    want;
        f    = out_flit[d];
        s    = int'(f.src);
        want = -1;
        if (int'(f.dest) != d) report_mismatch($sformatf("out_flit[%0d].dest", d), d, f.dest);
        if (timed) begin
            // serial phases hold a single packet in flight
            for (int i = 0; i < num_pkt; i++) begin
                if (golden[i][3:0] == ph && sent[i] && !got[i]) want = i;
            end
            if (want >= 0 && s != int'(golden[want][19:16])) begin
                report_mismatch($sformatf("out_flit[%0d].src", d), golden[want][19:16], s);
            end
        end
        idx = find_packet(ph, s, d, pair_cnt[s][d]);   // oldest still owed on this pair
        if (idx < 0) begin
            report_problem($sformatf("endpoint %0d got an extra flit from %0d", d, s));
        end else if (!sent[idx]) begin
            report_problem($sformatf("endpoint %0d got a flit before it was sent", d));
        end else begin
            if (f.data != golden[idx][11:4]) begin
                report_mismatch($sformatf("out_flit[%0d].data", d), golden[idx][11:4], f.data);
            end
            if (timed && (cycle_cnt - acc_cycle[idx]) != hop_latency(s, d)) begin
                report_mismatch($sformatf("out_valid[%0d] latency", d), hop_latency(s, d),
                                cycle_cnt - acc_cycle[idx]);
            end
            got[idx] = 1'b1;
            pair_cnt[s][d]++;
        end
    endtask

    // earliest unsent packet per source or a single one in flight when serial
    task automatic update_offers(input int ph, input bit serial);
        bit busy;
        int first;
        busy  = 1'b0;
        first = -1;
        for (int e = 0; e < NE; e++) offer[e] = -1;
        for (int i = num_pkt - 1; i >= 0; i--) begin
            if (golden[i][3:0] == ph && sent[i] && !got[i]) busy = 1'b1;
            if (golden[i][3:0] == ph && !sent[i]) begin
                offer[golden[i][19:16]] = i;    // loop runs backwards so earliest wins
                first = i;
            end
        end
        if (serial) begin
            for (int e = 0; e < NE; e++) offer[e] = -1;
            if (!busy && first >= 0) offer[golden[first][19:16]] = first;
        end
        for (int e = 0; e < NE; e++) begin
            in_valid[e] = (offer[e] >= 0);
            if (offer[e] >= 0) begin
                in_flit[e] = {addr_t'(golden[offer[e]][15:12]),
                              addr_t'(golden[offer[e]][19:16]), golden[offer[e]][11:4]};
            end
        end
    endtask

    task automatic run_phase(input int ph, input string name, input bit serial, input bit squeeze);
        int total;
        int done;
        int err_start;
        int hold;
        bit saw_full;
        total     = 0;
        done      = 0;
        err_start = errors;
        hold      = 10;                         // sinks stalled at first so FIFOs fill
        saw_full  = 1'b0;
        for (int i = 0; i < num_pkt; i++) begin
            sent[i] = 1'b0;
            got[i]  = 1'b0;
            if (golden[i][3:0] == ph) total++;
        end
        pair_cnt  = '{default: 0};
        out_ready = squeeze ? '0 : '1;
        update_offers(ph, serial);
        while (done < total) begin
            @(negedge clk);                     // handshakes settled before the next edge
            for (int e = 0; e < NE; e++) begin
                if (in_valid[e] && in_ready[e]) begin
                    sent[offer[e]]      = 1'b1;
                    acc_cycle[offer[e]] = cycle_cnt;
                end
                if (!in_ready[e]) saw_full = 1'b1;
            end
            for (int d = 0; d < NE; d++) begin
                if (out_valid[d] && out_ready[d]) begin
                    check_delivery(ph, d, serial);
                    done++;
                end
            end
            @(posedge clk);
            #1;
            update_offers(ph, serial);
            if (squeeze) begin
                hold--;
                for (int d = 0; d < NE; d++) begin
                    out_ready[d] = (hold <= 0) && (($random(seed) & 3) == 0);
                end
            end
        end
        in_valid  = '0;
        out_ready = '1;
        // any out_valid past the last golden flit is a stray
        for (int c = 0; c < 4; c++) begin
            if (out_valid !== '0) begin
                report_mismatch("out_valid after last delivery", 0, out_valid);
            end
            @(posedge clk);
            #1;
        end
        if (squeeze && !saw_full) report_problem("in_ready never fell with the outputs held");
        if (errors != err_start) tests_failed++;
        $display("test %0d %s: %s, %0d packets", ph, name,
                 (errors == err_start) ? "pass" : "fail", total);
    endtask

    initial begin : main
        int err_start;
        reset     = 1'b1;
        in_valid  = '0;
        out_ready = '1;
        for (int e = 0; e < NE; e++) in_flit[e] = '0;
        $readmemh("tree_noc_golden.txt", golden);
        num_pkt = 0;
        while (num_pkt < MAX_PKT && !$isunknown(golden[num_pkt])) num_pkt++;
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        // reset state with nothing driven yet
        err_start = errors;
        if (out_valid !== '0) report_mismatch("out_valid", 0, out_valid);
        if (in_ready !== '1) report_mismatch("in_ready", (1 << NE) - 1, in_ready);
        if (num_pkt == 0) report_problem("golden file holds no packets");
        if (errors != err_start) tests_failed++;
        $display("test 0 reset state: %s", (errors == err_start) ? "pass" : "fail");
        run_phase(1, "local delivery", 1'b1, 1'b0);
        run_phase(2, "cross-root delivery", 1'b1, 1'b0);
        run_phase(3, "contention on one endpoint", 1'b0, 1'b0);
        run_phase(4, "spread traffic", 1'b0, 1'b0);
        run_phase(5, "back-pressure", 1'b0, 1'b1);
        $display("6 tests, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tree_noc_top.sv */
`timescale 1ns/1ps

// tree NoC, one root with K ports and K+1 port routers below it
// router ids run from the root down, layer by layer
module tree_noc_top
    import tree_noc_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic [NE-1:0] in_valid,
    output wire  [NE-1:0] in_ready,
    input  flit_t         in_flit [NE],
    output wire  [NE-1:0] out_valid,
    input  logic [NE-1:0] out_ready,
    output wire  flit_t   out_flit [NE]
);

    // router side of every link, [router id][port]
    wire        [MAX_P-1:0] rin_valid  [NR];
    wire        [MAX_P-1:0] rin_ready  [NR];
    wire flit_t             rin_flit   [NR][MAX_P];
    wire        [MAX_P-1:0] rout_valid [NR];
    wire        [MAX_P-1:0] rout_ready [NR];
    wire flit_t             rout_flit  [NR][MAX_P];

    // root is id 0, only K ports so slot K stays open
    tree_router #(
        .P    (K),
        .LAYER(L - 1),
        .POS  (0)
    ) i_root (
        .clk      (clk),
        .reset    (reset),
        .in_valid (rin_valid[0][K-1:0]),
        .in_ready (rin_ready[0][K-1:0]),
        .in_flit  (rin_flit[0][0:K-1]),
        .out_valid(rout_valid[0][K-1:0]),
        .out_ready(rout_ready[0][K-1:0]),
        .out_flit (rout_flit[0][0:K-1])
    );

    for (genvar lyr = 0; lyr < L - 1; lyr++) begin : g_layer
        for (genvar pos = 0; pos < powi(K, L - 1 - lyr); pos++) begin : g_pos
            localparam int RID     = router_index(lyr) + pos;
            localparam int UP_ID   = router_index(lyr + 1) + pos / K;   // parent
            localparam int UP_PORT = pos % K;                           // our slot there

            tree_router #(
                .P    (K + 1),
                .LAYER(lyr),
                .POS  (pos)
            ) i_router (
                .clk      (clk),
                .reset    (reset),
                .in_valid (rin_valid[RID]),
                .in_ready (rin_ready[RID]),
                .in_flit  (rin_flit[RID]),
                .out_valid(rout_valid[RID]),
                .out_ready(rout_ready[RID]),
                .out_flit (rout_flit[RID])
            );

            // up port K towards the parent
            assign rin_valid[UP_ID][UP_PORT] = rout_valid[RID][K];
            assign rin_flit[UP_ID][UP_PORT]  = rout_flit[RID][K];
            assign rout_ready[RID][K]        = rin_ready[UP_ID][UP_PORT];
            // and back down
            assign rin_valid[RID][K]          = rout_valid[UP_ID][UP_PORT];
            assign rin_flit[RID][K]           = rout_flit[UP_ID][UP_PORT];
            assign rout_ready[UP_ID][UP_PORT] = rin_ready[RID][K];
        end
    end

    // endpoint e on leaf e/K, port e mod K
    for (genvar e = 0; e < NE; e++) begin : g_ep
        localparam int RID   = router_index(0) + e / K;
        localparam int RPORT = e % K;

        assign rin_valid[RID][RPORT]  = in_valid[e];
        assign rin_flit[RID][RPORT]   = in_flit[e];
        assign in_ready[e]            = rin_ready[RID][RPORT];
        assign out_valid[e]           = rout_valid[RID][RPORT];
        assign out_flit[e]            = rout_flit[RID][RPORT];
        assign rout_ready[RID][RPORT] = out_ready[e];
    end

endmodule

/* tree_router.sv */
`timescale 1ns/1ps

// P-port tree router
// input FIFOs, up/down routing on the head flit, round-robin per output
// no wormhole state since every packet is a single flit
module tree_router
    import tree_noc_pkg::*;
#(
    parameter int P     = K + 1,    // K at the root
    parameter int LAYER = 0,        // 0 at the leaves
    parameter int POS   = 0         // position within the layer
) (
    input  logic         clk,
    input  logic         reset,
    input  logic [P-1:0] in_valid,
    output logic [P-1:0] in_ready,
    input  flit_t        in_flit [P],
    output logic [P-1:0] out_valid,
    input  logic [P-1:0] out_ready,
    output flit_t        out_flit [P]
);

    logic [P-1:0]     head_valid;   // FIFO not empty
    flit_t            head_flit [P];
    logic [P-1:0]     pop;          // head leaves this cycle
    logic [PORTW-1:0] route [P];    // output port wanted by each head
    logic [P-1:0]     req [P];      // [output][input]
    logic [P-1:0]     gnt [P];      // [output][input]

    for (genvar i = 0; i < P; i++) begin : g_in

        flit_fifo #(
            .DEPTH(FIFO_DEPTH)
        ) i_fifo (
            .clk      (clk),
            .reset    (reset),
            .in_valid (in_valid[i]),
            .in_ready (in_ready[i]),
            .in_flit  (in_flit[i]),
            .out_valid(head_valid[i]),
            .out_ready(pop[i]),
            .out_flit (head_flit[i])
        );

        // up/down routing
        // our subtree if the digits above LAYER spell POS
        always_comb begin : route_calc
            logic match;
            match = 1'b1;
            for (int j = LAYER + 1; j < L; j++) begin
                // digit j of POS sits at weight K^(j-LAYER-1)
                if (int'(digit(head_flit[i].dest, j)) != (POS / powi(K, j - LAYER - 1)) % K) begin
                    match = 1'b0;
                end
            end
            if (match) begin
                route[i] = PORTW'(digit(head_flit[i].dest, LAYER));   // down
            end else begin
                route[i] = PORTW'(K);           // up port, never taken at the root
            end
        end

    end

    // each valid head asks exactly one output
    always_comb begin : req_matrix
        for (int o = 0; o < P; o++) begin
            for (int i = 0; i < P; i++) begin
                req[o][i] = head_valid[i] && (route[i] == PORTW'(o));
            end
        end
    end

    for (genvar o = 0; o < P; o++) begin : g_out

        rr_arbiter #(
            .N(P)
        ) i_arb (
            .clk    (clk),
            .reset  (reset),
            .request(req[o]),
            .grant  (gnt[o]),
            .advance(out_valid[o] & out_ready[o])
        );

        assign out_valid[o] = |gnt[o];          // grant implies a valid head

        // crossbar column
        always_comb begin : out_mux
            out_flit[o] = head_flit[0];
            for (int i = 0; i < P; i++) begin
                if (gnt[o][i]) out_flit[o] = head_flit[i];
            end
        end

    end

    // a head pops when the output it holds is taken
    always_comb begin : pop_calc
        pop = '0;
        for (int o = 0; o < P; o++) begin
            for (int i = 0; i < P; i++) begin
                if (gnt[o][i] && out_ready[o]) begin
                    pop[i] = 1'b1;
                end
            end
        end
    end

endmodule
